//--- include/liic_cfg.svh
// sizes and timing constants of the downstream link
// include wherever a width, the reset pulse shape or the sync depth is needed

`ifndef LIIC_CFG_SVH
`define LIIC_CFG_SVH

// stream and control/status widths
`define LIIC_ST_WIDTH       8       // user and link stream word
`define LIIC_CS_WIDTH       16      // control/status data bus
`define LIIC_CNT_WIDTH      16      // traffic counters, saturating

// link layer reset while link is down
`define LIIC_RST_LENGTH     4       // pulse high time in cycles
`define LIIC_RST_PERIOD     32      // pulse repetition in cycles

// linkup input synchronizer
`define LIIC_SYNC_STAGES    3       // flops in the chain

`endif

//--- source/liic_pkg.sv
// common types of the downstream link
// modules refer to them by scoped name, sizes come from the config header

`include "liic_cfg.svh"

package liic_pkg;

    // stream data word, same width on user and link side
    typedef logic [`LIIC_ST_WIDTH - 1 : 0]  st_word_t;

    // control/status data word
    typedef logic [`LIIC_CS_WIDTH - 1 : 0]  cs_word_t;

    // traffic counter
    typedef logic [`LIIC_CNT_WIDTH - 1 : 0] cnt_t;

    // control/status register address
    typedef logic [3 : 0]                   cs_addr_t;

    // register map
    typedef enum cs_addr_t {
        CSR_STATUS   = 4'd0,    // bit 0 is linkup
        CSR_IN_RCVD  = 4'd1,    // link inbound words accepted
        CSR_IN_LOST  = 4'd2,    // inbound packets dropped
        CSR_OUT_SENT = 4'd3,    // link outbound words delivered
        CSR_OUT_LOST = 4'd4     // user packets dropped
    } csr_reg_e;

endpackage: liic_pkg

//--- source/liic_event_if.sv
// per-cycle traffic events from the stream adapter to the register block
// every strobe is high for one cycle per event, no handshake

interface liic_event_if;

    logic   in_rcvd;    // link inbound word accepted
    logic   in_lost;    // inbound packet dropped, on its eop
    logic   out_sent;   // link outbound word delivered
    logic   out_lost;   // user packet dropped, on its eop

    // event source side
    modport adapter (
        output in_rcvd,
        output in_lost,
        output out_sent,
        output out_lost
    );

    // counting side
    modport csr (
        input  in_rcvd,
        input  in_lost,
        input  out_sent,
        input  out_lost
    );

endinterface: liic_event_if

//--- source/liic_link_monitor.sv
// brings the link layer linkup into the clock domain and drives
// periodic link layer reset pulses for as long as the link is down

`include "liic_cfg.svh"

module liic_link_monitor (
    input  logic    rst,
    input  logic    clk,
    input  logic    ll_linkup,  // async, straight from the link layer
    output logic    linkup,     // synchronized
    output logic    ll_reset    // reset pulses to the link layer
);
    localparam int unsigned SYNC_N = `LIIC_SYNC_STAGES;
    localparam int unsigned CNT_W  = $clog2(`LIIC_RST_PERIOD);

    logic [SYNC_N - 1 : 0]  sync_ff;    // synchronizer chain
    logic [CNT_W - 1 : 0]   period_cnt; // position inside reset period
    logic                   period_end;

    // shift linkup in at the low end
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_ff <= '0;                                  // link assumed down
        end else begin
            sync_ff <= {sync_ff[SYNC_N - 2 : 0], ll_linkup};
        end
    end

    assign linkup = sync_ff[SYNC_N - 1];                    // last stage only

    assign period_end = (period_cnt == CNT_W'(`LIIC_RST_PERIOD - 1));

    // runs only while down, parked at zero once up
    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;                               // first pulse at once
        end else if (linkup) begin
            period_cnt <= '0;
        end else if (period_end) begin
            period_cnt <= '0;                               // wrap, next pulse
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // head of every period
    assign ll_reset = ~linkup & (period_cnt < CNT_W'(`LIIC_RST_LENGTH));

    // the link is never reset while it reports up
    a_no_reset_when_up: assert property (@(posedge clk) disable iff (rst)
        linkup |-> !ll_reset);

    // losing the link restarts the pulse train without delay
    a_pulse_on_loss: assert property (@(posedge clk) disable iff (rst)
        $fell(linkup) |-> ll_reset);

endmodule: liic_link_monitor

//--- source/liic_ll_adapter.sv
// joins one user stream pair to one link layer stream pair
// adds sop towards the link, strips it towards the user, drops packets begun while down

module liic_ll_adapter (
    input  logic                rst,
    input  logic                clk,
    input  logic                linkup,

    // user side, into the link
    input  liic_pkg::st_word_t  usr_i_dat,
    input  logic                usr_i_val,
    input  logic                usr_i_eop,
    output logic                usr_i_rdy,

    // link outbound
    output liic_pkg::st_word_t  ll_o_dat,
    output logic                ll_o_val,
    output logic                ll_o_sop,
    output logic                ll_o_eop,
    input  logic                ll_o_rdy,

    // link inbound
    input  liic_pkg::st_word_t  ll_i_dat,
    input  logic                ll_i_val,
    input  logic                ll_i_sop,
    input  logic                ll_i_eop,
    output logic                ll_i_rdy,

    // user side, out of the link
    output liic_pkg::st_word_t  usr_o_dat,
    output logic                usr_o_val,
    output logic                usr_o_eop,
    input  logic                usr_o_rdy,

    liic_event_if.adapter       ev
);
    // outbound path state
    logic   o_full;         // output register holds a word
    logic   o_first;        // next user word opens a packet
    logic   o_drop_q;       // current user packet is being dropped
    logic   o_drop;
    logic   usr_acc;
    logic   o_load;

    // inbound path state
    logic   i_full;
    logic   i_drop_q;       // current link packet is being dropped
    logic   i_drop;
    logic   ll_acc;
    logic   i_load;

    // outbound, linkup sampled on the packet's first word
    assign o_drop    = o_first ? ~linkup : o_drop_q;
    assign usr_i_rdy = o_drop | ~o_full | ll_o_rdy;         // drop sink or free slot
    assign usr_acc   = usr_i_val & usr_i_rdy;
    assign o_load    = usr_acc & ~o_drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_full   <= 1'b0;
            o_first  <= 1'b1;                               // sop on first word
            o_drop_q <= 1'b0;
        end else begin
            o_full <= o_load | (o_full & ~ll_o_rdy);        // hold under back-pressure
            if (usr_acc) begin
                o_first  <= usr_i_eop;                      // eop opens next packet
                o_drop_q <= o_drop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_load) begin
            ll_o_dat <= usr_i_dat;
            ll_o_sop <= o_first;
            ll_o_eop <= usr_i_eop;
        end
    end

    assign ll_o_val = o_full;

    // inbound, link supplies sop itself
    assign i_drop   = ll_i_sop ? ~linkup : i_drop_q;
    assign ll_i_rdy = i_drop | ~i_full | usr_o_rdy;
    assign ll_acc   = ll_i_val & ll_i_rdy;
    assign i_load   = ll_acc & ~i_drop;

    always_ff @(posedge clk) begin
        if (rst) begin
            i_full   <= 1'b0;
            i_drop_q <= 1'b0;
        end else begin
            i_full <= i_load | (i_full & ~usr_o_rdy);
            if (ll_acc) begin
                i_drop_q <= i_drop;                         // carried to eop
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            usr_o_dat <= ll_i_dat;                          // sop dropped here
            usr_o_eop <= ll_i_eop;
        end
    end

    assign usr_o_val = i_full;

    // traffic events, counted one edge later
    assign ev.in_rcvd  = ll_acc;                            // dropped words too
    assign ev.in_lost  = ll_acc & i_drop & ll_i_eop;
    assign ev.out_sent = ll_o_val & ll_o_rdy;
    assign ev.out_lost = usr_acc & o_drop & usr_i_eop;

    // a stalled outbound word stays put until the link takes it
    a_o_hold: assert property (@(posedge clk) disable iff (rst)
        ll_o_val && !ll_o_rdy |=> ll_o_val && $stable({ll_o_dat, ll_o_sop, ll_o_eop}));

endmodule: liic_ll_adapter

//--- source/liic_csr.sv
// control/status registers of the downstream link
// status word plus four saturating traffic counters, reads answer one cycle later

module liic_csr (
    input  logic                rst,
    input  logic                clk,
    input  logic                linkup,
    liic_event_if.csr           ev,

    // control/status bus
    input  liic_pkg::cs_addr_t  cs_addr,
    input  logic                cs_wreq,
    input  liic_pkg::cs_word_t  cs_wdat,
    input  logic                cs_rreq,
    output liic_pkg::cs_word_t  cs_rdat,
    output logic                cs_rval
);
    localparam int unsigned N_CNT = 4;

    liic_pkg::cnt_t         cnt [N_CNT];    // index is address minus one
    logic [N_CNT - 1 : 0]   ev_hit;

    // same order as the register map
    assign ev_hit = {ev.out_lost, ev.out_sent, ev.in_lost, ev.in_rcvd};

    // counters, a write clears and beats an event
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_CNT; i++) begin
                if (cs_wreq && (cs_addr == liic_pkg::cs_addr_t'(i + 1))) begin
                    cnt[i] <= '0;                           // data ignored
                end else if (ev_hit[i] && (cnt[i] != '1)) begin
                    cnt[i] <= cnt[i] + 1'b1;                // sticks at all ones
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_rval <= 1'b0;
        end else begin
            cs_rval <= cs_rreq;                             // fixed latency of one
        end
    end

    // read data sampled with the request
    always_ff @(posedge clk) begin
        if (cs_rreq) begin
            case (cs_addr)
                liic_pkg::CSR_STATUS:   cs_rdat <= liic_pkg::cs_word_t'(linkup);
                liic_pkg::CSR_IN_RCVD:  cs_rdat <= liic_pkg::cs_word_t'(cnt[0]);
                liic_pkg::CSR_IN_LOST:  cs_rdat <= liic_pkg::cs_word_t'(cnt[1]);
                liic_pkg::CSR_OUT_SENT: cs_rdat <= liic_pkg::cs_word_t'(cnt[2]);
                liic_pkg::CSR_OUT_LOST: cs_rdat <= liic_pkg::cs_word_t'(cnt[3]);
                default:                cs_rdat <= '0;      // unused address
            endcase
        end
    end

    // every read request is answered on the next cycle and only then
    a_rval_latency: assert property (@(posedge clk) disable iff (rst)
        cs_rval == $past(cs_rreq));

    // the bus master drives a defined address and data with each write
    a_wreq_known: assert property (@(posedge clk) disable iff (rst)
        cs_wreq |-> !$isunknown({cs_addr, cs_wdat}));

endmodule: liic_csr

//--- source/liic_dn_link.sv
// downstream end of the link independent interconnect
// one user stream pair over the link low priority channel, with status registers

module liic_dn_link (
    input  logic                rst,
    input  logic                clk,

    // control/status bus
    input  liic_pkg::cs_addr_t  cs_addr,
    input  logic                cs_wreq,
    input  liic_pkg::cs_word_t  cs_wdat,
    input  logic                cs_rreq,
    output liic_pkg::cs_word_t  cs_rdat,
    output logic                cs_rval,

    // user stream into the link
    input  liic_pkg::st_word_t  st_i_dat,
    input  logic                st_i_val,
    input  logic                st_i_eop,
    output logic                st_i_rdy,

    // user stream out of the link
    output liic_pkg::st_word_t  st_o_dat,
    output logic                st_o_val,
    output logic                st_o_eop,
    input  logic                st_o_rdy,

    // link layer control
    input  logic                ll_linkup,  // async
    output logic                ll_reset,

    // link layer low priority inbound
    input  liic_pkg::st_word_t  lllp_i_dat,
    input  logic                lllp_i_val,
    input  logic                lllp_i_sop,
    input  logic                lllp_i_eop,
    output logic                lllp_i_rdy,

    // link layer low priority outbound
    output liic_pkg::st_word_t  lllp_o_dat,
    output logic                lllp_o_val,
    output logic                lllp_o_sop,
    output logic                lllp_o_eop,
    input  logic                lllp_o_rdy
);
    logic           linkup;                                 // synchronized state
    liic_event_if   events ();                              // adapter to csr

    liic_link_monitor the_liic_link_monitor (
        .rst        (rst),
        .clk        (clk),
        .ll_linkup  (ll_linkup),
        .linkup     (linkup),
        .ll_reset   (ll_reset)
    );

    liic_ll_adapter the_liic_ll_adapter (
        .rst        (rst),
        .clk        (clk),
        .linkup     (linkup),
        .usr_i_dat  (st_i_dat),     // user in goes out on the link
        .usr_i_val  (st_i_val),
        .usr_i_eop  (st_i_eop),
        .usr_i_rdy  (st_i_rdy),
        .ll_o_dat   (lllp_o_dat),
        .ll_o_val   (lllp_o_val),
        .ll_o_sop   (lllp_o_sop),
        .ll_o_eop   (lllp_o_eop),
        .ll_o_rdy   (lllp_o_rdy),
        .ll_i_dat   (lllp_i_dat),   // link in goes out to the user
        .ll_i_val   (lllp_i_val),
        .ll_i_sop   (lllp_i_sop),
        .ll_i_eop   (lllp_i_eop),
        .ll_i_rdy   (lllp_i_rdy),
        .usr_o_dat  (st_o_dat),
        .usr_o_val  (st_o_val),
        .usr_o_eop  (st_o_eop),
        .usr_o_rdy  (st_o_rdy),
        .ev         (events)
    );

    liic_csr the_liic_csr (
        .rst        (rst),
        .clk        (clk),
        .linkup     (linkup),
        .ev         (events),
        .cs_addr    (cs_addr),
        .cs_wreq    (cs_wreq),
        .cs_wdat    (cs_wdat),
        .cs_rreq    (cs_rreq),
        .cs_rdat    (cs_rdat),
        .cs_rval    (cs_rval)
    );

endmodule: liic_dn_link

//--- bench/liic_dn_link_tb.sv
// testbench of the downstream link, random packets both ways against a queue model
// runs reset pulse, link up, link down and register phases, then prints the verdict

`include "liic_cfg.svh"

module liic_dn_link_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 5;
    localparam int PERIOD      = `LIIC_RST_PERIOD;
    localparam int N_UP        = 24;                    // packets per direction, link up
    localparam int N_DOWN      = 8;                     // packets per direction, link down
    localparam int N_UP2       = 6;                     // after the link returns
    localparam int DRAIN_MAX   = 64;
    localparam int PKT_CYCLES  = 8 * 4 + 4;             // 8 words with stalls plus gap
    localparam int PLAN_CYCLES = RST_CYCLES + 2 * PERIOD
                               + (N_UP + N_DOWN + N_UP2) * PKT_CYCLES
                               + 3 * (`LIIC_SYNC_STAGES + 2) + 3 * DRAIN_MAX + 16 * 4 + 40;

    logic                   clk;
    logic                   rst;
    liic_pkg::cs_addr_t     cs_addr;
    logic                   cs_wreq;
    liic_pkg::cs_word_t     cs_wdat;
    logic                   cs_rreq;
    liic_pkg::cs_word_t     cs_rdat;
    logic                   cs_rval;
    liic_pkg::st_word_t     st_i_dat, st_o_dat, lllp_i_dat, lllp_o_dat;
    logic                   st_i_val, st_i_eop, st_i_rdy;
    logic                   st_o_val, st_o_eop, st_o_rdy;
    logic                   ll_linkup, ll_reset;
    logic                   lllp_i_val, lllp_i_sop, lllp_i_eop, lllp_i_rdy;
    logic                   lllp_o_val, lllp_o_sop, lllp_o_eop, lllp_o_rdy;

    logic [`LIIC_ST_WIDTH + 1 : 0]  out_q [$];          // {sop, eop, dat} towards link
    logic [`LIIC_ST_WIDTH : 0]      in_q [$];           // {eop, dat} towards user
    liic_pkg::cnt_t         m_in_rcvd, m_in_lost, m_out_sent, m_out_lost;
    logic                   up_settled;                 // link up and synchronized
    int                     errors;

    liic_dn_link u_liic_dn_link (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic liic_pkg::cnt_t sat_add(input liic_pkg::cnt_t c, input int n);
        longint sum;
        sum = longint'(c) + n;
        if (sum > longint'({`LIIC_CNT_WIDTH{1'b1}})) return '1;  // counters stick at max
        return liic_pkg::cnt_t'(sum);
    endfunction

    task automatic check_word(input string name, input liic_pkg::st_word_t exp, act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input liic_pkg::cs_word_t exp, act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // user packet into the link, dropped by the model while down
    task automatic send_user_pkt(input int n, input logic up);
        liic_pkg::st_word_t d;
        for (int i = 0; i < n; i++) begin
            d = liic_pkg::st_word_t'($urandom);
            @(negedge clk);
            st_i_val = 1'b1;
            st_i_dat = d;
            st_i_eop = (i == n - 1);
            @(posedge clk);
            if (!up) check_flag("user in rdy while down", 1'b1, st_i_rdy);
            while (!st_i_rdy) @(posedge clk);           // held until taken
            if (up) out_q.push_back({(i == 0), (i == n - 1), d});
        end
        @(negedge clk);
        st_i_val = 1'b0;
        st_i_eop = 1'b0;
        if (up) m_out_sent = sat_add(m_out_sent, n);
        else m_out_lost = sat_add(m_out_lost, 1);
        repeat ($urandom_range(0, 3)) @(negedge clk);   // gap
    endtask

    // link packet towards the user, every accepted word counts
    task automatic send_link_pkt(input int n, input logic up);
        liic_pkg::st_word_t d;
        for (int i = 0; i < n; i++) begin
            d = liic_pkg::st_word_t'($urandom);
            @(negedge clk);
            lllp_i_val = 1'b1;
            lllp_i_dat = d;
            lllp_i_sop = (i == 0);
            lllp_i_eop = (i == n - 1);
            @(posedge clk);
            if (!up) check_flag("link in rdy while down", 1'b1, lllp_i_rdy);
            while (!lllp_i_rdy) @(posedge clk);
            if (up) in_q.push_back({(i == n - 1), d});
        end
        @(negedge clk);
        lllp_i_val = 1'b0;
        lllp_i_sop = 1'b0;
        lllp_i_eop = 1'b0;
        m_in_rcvd = sat_add(m_in_rcvd, n);
        if (!up) m_in_lost = sat_add(m_in_lost, 1);
        repeat ($urandom_range(0, 3)) @(negedge clk);
    endtask

    task automatic send_both(input int n_pkt, input logic up);
        fork
            repeat (n_pkt) send_user_pkt($urandom_range(1, 8), up);
            repeat (n_pkt) send_link_pkt($urandom_range(1, 8), up);
        join
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while ((out_q.size() != 0 || in_q.size() != 0) && n < DRAIN_MAX) begin
            @(posedge clk);
            n++;
        end
        if (out_q.size() != 0) begin
            errors++;
            $display("%s: %0d words never left on link outbound", name, out_q.size());
        end
        if (in_q.size() != 0) begin
            errors++;
            $display("%s: %0d words never reached the user stream", name, in_q.size());
        end
        repeat (2) @(posedge clk);                      // last events into the counters
    endtask

    task automatic set_link(input logic up);
        @(negedge clk);
        ll_linkup  = up;
        up_settled = 1'b0;
        repeat (`LIIC_SYNC_STAGES + 2) @(posedge clk);
        up_settled = up;
    endtask

    task automatic read_reg(input string name, input liic_pkg::cs_addr_t addr,
                            input liic_pkg::cs_word_t exp);
        @(negedge clk);
        cs_addr = addr;
        cs_rreq = 1'b1;
        @(negedge clk);
        cs_rreq = 1'b0;
        @(posedge clk);                                 // answer cycle
        check_flag({name, " rval"}, 1'b1, cs_rval);
        check_reg(name, exp, cs_rdat);
    endtask

    task automatic clear_reg(input liic_pkg::cs_addr_t addr);
        @(negedge clk);
        cs_addr = addr;
        cs_wdat = liic_pkg::cs_word_t'($urandom);       // any data clears
        cs_wreq = 1'b1;
        @(negedge clk);
        cs_wreq = 1'b0;
    endtask

    task automatic read_counters(input string phase);
        read_reg({phase, " status"}, liic_pkg::CSR_STATUS, liic_pkg::cs_word_t'(up_settled));
        read_reg({phase, " in_rcvd"}, liic_pkg::CSR_IN_RCVD, m_in_rcvd);
        read_reg({phase, " in_lost"}, liic_pkg::CSR_IN_LOST, m_in_lost);
        read_reg({phase, " out_sent"}, liic_pkg::CSR_OUT_SENT, m_out_sent);
        read_reg({phase, " out_lost"}, liic_pkg::CSR_OUT_LOST, m_out_lost);
    endtask

    // back-pressure on both outputs
    initial begin
        forever begin
            @(negedge clk);
            lllp_o_rdy = ($urandom_range(0, 3) != 0);
            st_o_rdy   = ($urandom_range(0, 3) != 0);
        end
    end

    initial begin : watch_outputs
        logic [`LIIC_ST_WIDTH + 1 : 0]  o;
        logic [`LIIC_ST_WIDTH : 0]      u;
        forever begin
            @(posedge clk);
            if (up_settled) check_flag("ll_reset while up", 1'b0, ll_reset);
            if (!rst && lllp_o_val && lllp_o_rdy) begin
                if (out_q.size() == 0) begin
                    errors++;
                    $display("link outbound delivered a word that was never expected");
                end else begin
                    o = out_q.pop_front();
                    check_word("link out data", o[`LIIC_ST_WIDTH - 1 : 0], lllp_o_dat);
                    check_flag("link out sop", o[`LIIC_ST_WIDTH + 1], lllp_o_sop);
                    check_flag("link out eop", o[`LIIC_ST_WIDTH], lllp_o_eop);
                end
            end
            if (!rst && st_o_val && st_o_rdy) begin
                if (in_q.size() == 0) begin
                    errors++;
                    $display("user stream delivered a word that was never expected");
                end else begin
                    u = in_q.pop_front();
                    check_word("user out data", u[`LIIC_ST_WIDTH - 1 : 0], st_o_dat);
                    check_flag("user out eop", u[`LIIC_ST_WIDTH], st_o_eop);
                end
            end
        end
    end

    initial begin : watchdog
        #(PLAN_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired after %0d cycles, the run hung", PLAN_CYCLES * 2);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h5127));
        rst = 1'b1;
        {cs_addr, cs_wreq, cs_wdat, cs_rreq} = '0;
        {st_i_dat, st_i_val, st_i_eop, st_o_rdy} = '0;
        {lllp_i_dat, lllp_i_val, lllp_i_sop, lllp_i_eop, lllp_o_rdy} = '0;
        ll_linkup  = 1'b0;
        up_settled = 1'b0;
        {m_in_rcvd, m_in_lost, m_out_sent, m_out_lost} = '0;
        errors = 0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // link down, pulse train from reset on
        for (int i = 0; i < 2 * PERIOD; i++) begin
            @(posedge clk);
            check_flag("ll_reset pulse", (i % PERIOD) < `LIIC_RST_LENGTH, ll_reset);
            check_flag("link out val after reset", 1'b0, lllp_o_val);
            check_flag("user out val after reset", 1'b0, st_o_val);
        end

        set_link(1'b1);
        send_both(N_UP, 1'b1);
        wait_drain("link up");
        read_counters("link up");

        clear_reg(liic_pkg::CSR_IN_RCVD);               // counters restart from zero
        clear_reg(liic_pkg::CSR_OUT_SENT);
        m_in_rcvd  = '0;
        m_out_sent = '0;
        read_counters("after clear");
        read_reg("unused address", 4'd9, '0);

        set_link(1'b0);
        send_both(N_DOWN, 1'b0);
        wait_drain("link down");
        read_counters("link down");

        set_link(1'b1);
        send_both(N_UP2, 1'b1);                         // sop restarts after drops
        wait_drain("link back");
        read_counters("link back");

        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule: liic_dn_link_tb

//--- liic_dn_link.f
+incdir+include
source/liic_pkg.sv
source/liic_event_if.sv
source/liic_link_monitor.sv
source/liic_ll_adapter.sv
source/liic_csr.sv
source/liic_dn_link.sv
bench/liic_dn_link_tb.sv

//--- Bender.yml
package:
  name: liic_dn_link

export_include_dirs:
  - include

sources:
  - files:
      - source/liic_pkg.sv
      - source/liic_event_if.sv
      - source/liic_link_monitor.sv
      - source/liic_ll_adapter.sv
      - source/liic_csr.sv
      - source/liic_dn_link.sv
  - target: test
    files:
      - bench/liic_dn_link_tb.sv
